// ==== tests/soc_vectors.txt ====
# Columns: cmd addr data sel expected, hex. R read, W write, P pins (addr is the port),
# N idle data cycles then check addr 0 pulses, 1 gp0_o, 2 intrqst_o, 3 sys_rst_o; X reset window.
X 00000001 00000000 0 0000003F
N 00000000 00000000 0 00000000
N 00000001 00000000 0 00000000
N 00000002 00000000 0 00000000
R 00000000 00000000 F 00070400
R 00000001 00000000 F 00068400
R 00000002 00000000 F 00068400
R 00000003 00000000 F 00000400
R 00000004 00000000 F 00000000
W 00000401 0000ABCD F 00000000
N 00000001 00000000 0 0000ABCD
W 00000401 00001234 2 00000000
R 00000401 00000000 F 000012CD
P 00000000 00005A5A 0 00000000
N 00000002 00000003 0 00000001
R 00000400 00000000 F 00005A5A
N 00000002 00000000 0 00000000
P 00000001 00000015 0 00000000
N 00000002 00000003 0 00000002
R 00000800 00000000 F 00000015
N 00000002 00000000 0 00000000
R 00001400 00000000 F 00000000
N 00000000 00000000 0 00000001
N 00000000 00000014 0 00000000
R 00001400 00000000 F 00000000
W 00001400 DEADBEEF F 00000000
N 00000000 00000082 0 00000000
R 00001400 00000000 F 00000000
N 00000000 00000002 0 00000001
W 000003FF 00000001 F 00000000
X 00000000 00000000 0 00000040
N 00000001 00000000 0 00000000
W 000003FF 00000003 F 00000000
X 00000000 00000000 0 00000040
W 000003FF 00000002 F 00000000
N 00000003 00000064 0 00000001
X 00000001 00000000 0 0000003F
R 00000000 00000000 F 00070400

// ==== files.f ====
design/soc_pkg.sv
design/soc_reset_ctrl.sv
design/pi1_decoder.sv
design/dev_table.sv
design/gpio_port.sv
design/soc_top.sv
tests/soc_tb_sva.sv
tests/soc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the SoC testbench with Verilator, then judges the log.
cd "$(dirname "$0")" || exit 1
log=sim.log
verilator --binary --assert --timing --timescale 1ns/1ps --top-module soc_tb -f files.f \
	> "$log" 2>&1 \
	&& ./obj_dir/Vsoc_tb >> "$log" 2>&1 \
	|| echo "TESTBENCH FAILED" >> "$log"
cat "$log"
grep -q "TESTBENCH FAILED" "$log" && echo "Simulation failed" && exit 1
echo "Simulation passed"
exit 0

// ==== tests/soc_tb.sv ====
// SoC testbench replaying bus and pin vectors from a file and checking every response.
module soc_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import soc_pkg::*;

	localparam string VECTOR_FILE = "tests/soc_vectors.txt";
	localparam int RESET_CYCLES = 16;

	logic                   clk100mhz_i = 1'b0;
	logic                   rst_p;
	pi1_req_t               req_i;
	pi1_rsp_t               rsp_o;
	logic [GP0IO_COUNT-1:0] gp0_i;
	logic [GP0IO_COUNT-1:0] gp0_o;
	logic [GP1IO_COUNT-1:0] gp1_i;
	logic [1:0]             intrqst_o;
	logic                   sys_rst_o;
	logic                   activity_o;

	// One queue per vector column.
	logic [7:0]  vec_cmd [$];
	logic [31:0] vec_addr [$];
	logic [31:0] vec_data [$];
	logic [31:0] vec_sel [$];
	logic [31:0] vec_exp [$];
	bit          vectors_loaded = 1'b0;
	int          act_pulses = 0;

	soc_top i_dut (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (rst_p),
		.req_i       (req_i),
		.rsp_o       (rsp_o),
		.gp0_i       (gp0_i),
		.gp0_o       (gp0_o),
		.gp1_i       (gp1_i),
		.intrqst_o   (intrqst_o),
		.sys_rst_o   (sys_rst_o),
		.activity_o  (activity_o)
	);

	always #5 clk100mhz_i = ~clk100mhz_i;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "Run stopped at the first error.");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("Mismatch at %0d ns: %s is 0x%08h, expected 0x%08h",
				$time, name, actual, expected));
		end
	endtask

	// Advance one clock period to the next falling edge where outputs are stable.
	task automatic step_cycle();
		logic had_req;
		had_req = (req_i.op != OP_NONE) && (sys_rst_o === 1'b0);
		@(negedge clk100mhz_i);
		req_i.op = OP_NONE;
		if (activity_o === 1'b1) begin
			act_pulses++;
		end
		if (rst_p == 1'b0 && had_req && rsp_o.rdy !== 1'b1) begin
			abort_run("A request got no ready pulse on the following edge.");
		end
		if (rst_p == 1'b0 && !had_req && rsp_o.rdy !== 1'b0) begin
			abort_run("A ready pulse arrived without a request in the cycle before.");
		end
	endtask

	task automatic issue_request(input logic [1:0] op, input logic [31:0] addr,
			input logic [31:0] data, input logic [31:0] sel, input logic [31:0] expected);
		req_i.op = op;
		req_i.addr.word = addr[ADDR_W-1:0];
		req_i.data = data;
		req_i.sel = sel[SEL_W-1:0];
		step_cycle();
		check_value("rsp_o.data", rsp_o.data, expected);
	endtask

	task automatic set_pins(input logic [31:0] port, input logic [31:0] value);
		if (port == 0) begin
			gp0_i = value[GP0IO_COUNT-1:0];
		end else begin
			gp1_i = value[GP1IO_COUNT-1:0];
		end
	endtask

	// Observed signal 0 is the pulse count since the last such check.
	task automatic idle_and_observe(input logic [31:0] what, input logic [31:0] cycles,
			input logic [31:0] expected);
		repeat (cycles) step_cycle();
		case (what)
			0: begin
				check_value("activity_o pulses", 32'(act_pulses), expected);
				act_pulses = 0;
			end
			1: check_value("gp0_o", 32'(gp0_o), expected);
			2: check_value("intrqst_o", 32'(intrqst_o), expected);
			3: check_value("sys_rst_o", 32'(sys_rst_o), expected);
			default: abort_run("An idle line names an unknown signal to observe.");
		endcase
	endtask

	task automatic measure_reset(input logic [31:0] pulse, input logic [31:0] expected);
		int cycles;
		if (pulse != 0) begin
			rst_p = 1'b1;
			repeat (RESET_CYCLES) step_cycle();
			rst_p = 1'b0;
		end
		cycles = 0;
		// Requests issued while held in reset must stay unanswered.
		do begin
			if (sys_rst_o === 1'b1) begin
				req_i.op = OP_READ;
				req_i.addr.word = '0;
			end
			step_cycle();
			cycles++;
		end while (sys_rst_o === 1'b1 && cycles < 190);
		check_value("sys_rst_o window", 32'(cycles), expected);
	endtask

	task automatic load_vectors();
		int fd;
		int fields;
		string line;
		logic [7:0] cmd;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] sel;
		logic [31:0] expected;
		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0) begin
			abort_run("The vector file could not be opened.");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			fields = $sscanf(line, "%c %h %h %h %h", cmd, addr, data, sel, expected);
			if (fields != 5) begin
				abort_run("A vector line does not hold five fields.");
			end
			vec_cmd.push_back(cmd);
			vec_addr.push_back(addr);
			vec_data.push_back(data);
			vec_sel.push_back(sel);
			vec_exp.push_back(expected);
		end
		$fclose(fd);
	endtask

	task automatic run_vector(input int i);
		case (vec_cmd[i])
			"R": issue_request(OP_READ, vec_addr[i], vec_data[i], vec_sel[i], vec_exp[i]);
			"W": issue_request(OP_WRITE, vec_addr[i], vec_data[i], vec_sel[i], vec_exp[i]);
			"P": set_pins(vec_addr[i], vec_data[i]);
			"N": idle_and_observe(vec_addr[i], vec_data[i], vec_exp[i]);
			"X": measure_reset(vec_addr[i], vec_exp[i]);
			default: abort_run("A vector line starts with an unknown command letter.");
		endcase
	endtask

	initial begin
		rst_p = 1'b1;
		req_i = '0;
		gp0_i = '0;
		gp1_i = '0;
		load_vectors();
		vectors_loaded = 1'b1;
		for (int i = 0; i < vec_cmd.size(); i++) begin
			run_vector(i);
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

	// Budget of 200 cycles per vector line plus a fixed margin.
	initial begin
		int limit;
		wait (vectors_loaded);
		limit = vec_cmd.size() * 200 + 2000;
		repeat (limit) @(posedge clk100mhz_i);
		abort_run("Watchdog expired before all vectors were run.");
	end

endmodule

// ==== tests/soc_tb_sva.sv ====
// Bus response and reset assertions for the SoC top level, bound into the design.
module soc_sva (
	input logic               clk100mhz_i,
	input logic               rst_p,
	input soc_pkg::pi1_req_t  req_i,
	input soc_pkg::pi1_rsp_t  rsp_o,
	input logic               sys_rst_o,
	input logic               activity_o
);
	timeunit 1ns;
	timeprecision 1ps;
	import soc_pkg::*;

	// Every accepted request is answered on the next edge.
	a_rdy_follows_req: assert property (@(posedge clk100mhz_i) disable iff (rst_p)
		((req_i.op != OP_NONE) && !sys_rst_o) |=> rsp_o.rdy)
		else $error("Request outside reset was not answered on the next edge.");

	a_no_rdy_without_req: assert property (@(posedge clk100mhz_i) disable iff (rst_p)
		(req_i.op == OP_NONE) |=> !rsp_o.rdy)
		else $error("Ready pulse without a request in the cycle before.");

	// The dimmed indicator never stays on for two cycles
	a_activity_single: assert property (@(posedge clk100mhz_i) disable iff (rst_p)
		activity_o |=> !activity_o)
		else $error("Activity indicator high in two consecutive cycles.");

	a_no_rdy_in_reset: assert property (@(posedge clk100mhz_i) disable iff (rst_p)
		sys_rst_o |-> !rsp_o.rdy)
		else $error("Ready pulse while the system reset is active.");

endmodule

bind soc_top soc_sva i_sva (
	.clk100mhz_i (clk100mhz_i),
	.rst_p       (rst_p),
	.req_i       (req_i),
	.rsp_o       (rsp_o),
	.sys_rst_o   (sys_rst_o),
	.activity_o  (activity_o)
);

// ==== design/soc_top.sv ====
// SoC top level tying reset control, bus decoder, device table and both GPIO ports together.
module soc_top (
	input  logic                             clk100mhz_i,
	input  logic                             rst_p,
	input  soc_pkg::pi1_req_t                req_i,
	output soc_pkg::pi1_rsp_t                rsp_o,
	input  logic [soc_pkg::GP0IO_COUNT-1:0]  gp0_i,
	output logic [soc_pkg::GP0IO_COUNT-1:0]  gp0_o,
	input  logic [soc_pkg::GP1IO_COUNT-1:0]  gp1_i,
	output logic [1:0]                       intrqst_o,
	output logic                             sys_rst_o,
	output logic                             activity_o
);
	import soc_pkg::*;

	rst_req_t rst_req;
	pi1_req_t dev_req [DEV_COUNT-1];
	pi1_rsp_t dev_rsp [DEV_COUNT-1];

	soc_reset_ctrl i_reset_ctrl (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (rst_p),
		.rst_req_i   (rst_req),
		.sys_rst_o   (sys_rst_o)
	);

	pi1_decoder i_decoder (
		.clk100mhz_i (clk100mhz_i),
		.sys_rst_i   (sys_rst_o),
		.req_i       (req_i),
		.dev_req_o   (dev_req),
		.dev_rsp_i   (dev_rsp),
		.rsp_o       (rsp_o),
		.activity_o  (activity_o)
	);

	dev_table i_dev_table (
		.clk100mhz_i (clk100mhz_i),
		.sys_rst_i   (sys_rst_o),
		.req_i       (dev_req[DEV_DEVTBL]),
		.rsp_o       (dev_rsp[DEV_DEVTBL]),
		.rst_req_o   (rst_req)
	);

	// Port 0 drives the board outputs directly.
	gpio_port #(
		.IO_COUNT (GP0IO_COUNT)
	) i_gp0io (
		.clk100mhz_i (clk100mhz_i),
		.sys_rst_i   (sys_rst_o),
		.req_i       (dev_req[DEV_GP0IO]),
		.rsp_o       (dev_rsp[DEV_GP0IO]),
		.io_i        (gp0_i),
		.io_o        (gp0_o),
		.intrqst_o   (intrqst_o[0])
	);

	// Port 1 is input only, buttons have no matching outputs.
	gpio_port #(
		.IO_COUNT (GP1IO_COUNT)
	) i_gp1io (
		.clk100mhz_i (clk100mhz_i),
		.sys_rst_i   (sys_rst_o),
		.req_i       (dev_req[DEV_GP1IO]),
		.rsp_o       (dev_rsp[DEV_GP1IO]),
		.io_i        (gp1_i),
		.io_o        (),
		.intrqst_o   (intrqst_o[1])
	);

endmodule

// ==== design/gpio_port.sv ====
// General-purpose I/O port with synchronized inputs, byte-writable outputs and change interrupt.
module gpio_port #(
	parameter int IO_COUNT = 16
) (
	input  logic                 clk100mhz_i,
	input  logic                 sys_rst_i,
	input  soc_pkg::pi1_req_t    req_i,
	output soc_pkg::pi1_rsp_t    rsp_o,
	input  logic [IO_COUNT-1:0]  io_i,
	output logic [IO_COUNT-1:0]  io_o,
	output logic                 intrqst_o
);
	import soc_pkg::*;

	logic [IO_COUNT-1:0]     sync1_q;
	logic [IO_COUNT-1:0]     sync2_q;
	logic [IO_COUNT-1:0]     prev_q;
	logic [DEV_OFFSET_W-1:0] offset;
	logic                    is_write;
	logic                    is_read;
	logic                    in_changed;
	logic                    rdy_q;
	logic [ARCH_W-1:0]       data_q;

	assign offset = req_i.addr.fields.offset;
	assign is_write = (req_i.op == OP_WRITE);
	assign is_read = (req_i.op != OP_NONE) && !is_write;
	assign in_changed = (sync2_q != prev_q);

	// Two-flop input synchronizer, plus the copy used for edge detection.
	always_ff @(posedge clk100mhz_i) begin
		sync1_q <= io_i;
		sync2_q <= sync1_q;
		prev_q <= sync2_q;
	end

	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			io_o <= '0;
		end else if (is_write && (offset == DEV_OFFSET_W'(1))) begin
			for (int b = 0; b < IO_COUNT; b++) begin
				if (req_i.sel[b / 8]) begin
					io_o[b] <= req_i.data[b];
				end
			end
		end
	end

	// A fresh change takes priority over the clear from reading offset 0.
	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			intrqst_o <= 1'b0;
		end else if (in_changed) begin
			intrqst_o <= 1'b1;
		end else if (is_read && (offset == '0)) begin
			intrqst_o <= 1'b0;
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= (req_i.op != OP_NONE);
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		data_q <= '0;
		if (is_read && (offset == '0)) begin
			data_q <= ARCH_W'(sync2_q);
		end else if (is_read && (offset == DEV_OFFSET_W'(1))) begin
			data_q <= ARCH_W'(io_o);
		end
	end

	assign rsp_o.rdy = rdy_q;
	assign rsp_o.data = data_q;

endmodule

// ==== design/dev_table.sv ====
// Device table with read-only per-device entries and the software reset control word.
module dev_table (
	input  logic               clk100mhz_i,
	input  logic               sys_rst_i,
	input  soc_pkg::pi1_req_t  req_i,
	output soc_pkg::pi1_rsp_t  rsp_o,
	output soc_pkg::rst_req_t  rst_req_o
);
	import soc_pkg::*;

	logic                    is_write;
	logic                    is_read;
	logic                    ctrl_wr;
	logic [DEV_OFFSET_W-1:0] offset;
	devtbl_entry_t           entry;
	logic                    rdy_q;
	logic [ARCH_W-1:0]       data_q;

	assign offset = req_i.addr.fields.offset;
	assign is_write = (req_i.op == OP_WRITE);
	assign is_read = (req_i.op != OP_NONE) && !is_write;
	assign ctrl_wr = is_write && (offset == DEV_OFFSET_W'(DEVTBL_CTRL_OFFSET));

	// Offsets past the last device read as zero.
	always_comb begin
		entry = '0;
		for (int i = 0; i < DEV_COUNT; i++) begin
			if (offset == DEV_OFFSET_W'(i)) begin
				entry.id = DEV_ID_TABLE[i];
				entry.useintr = DEV_USEINTR_TABLE[i];
				entry.mapsz = 15'(DEV_MAPSZ);
			end
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			rdy_q <= 1'b0;
			rst_req_o <= '0;
		end else begin
			rdy_q <= (req_i.op != OP_NONE);
			// Bits 1:0 select warm (01), cold (11) or power-off (10).
			rst_req_o.warm <= ctrl_wr && req_i.data[0];
			rst_req_o.pwroff <= ctrl_wr && (req_i.data[1:0] == 2'b10);
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		data_q <= is_read ? ARCH_W'(entry) : '0;
	end

	assign rsp_o.rdy = rdy_q;
	assign rsp_o.data = data_q;

endmodule

// ==== design/pi1_decoder.sv ====
// PI1 bus decoder routing requests to fixed device windows and answering invalid addresses.
module pi1_decoder (
	input  logic               clk100mhz_i,
	input  logic               sys_rst_i,
	input  soc_pkg::pi1_req_t  req_i,
	output soc_pkg::pi1_req_t  dev_req_o [soc_pkg::DEV_COUNT-1],
	input  soc_pkg::pi1_rsp_t  dev_rsp_i [soc_pkg::DEV_COUNT-1],
	output soc_pkg::pi1_rsp_t  rsp_o,
	output logic               activity_o
);
	import soc_pkg::*;

	logic [DEV_INDEX_W-1:0]     dev_index;
	logic                       req_valid;
	logic                       inv_hit;
	logic [DEV_SEL_W-1:0]       dev_sel_q;
	logic                       inv_rdy_q;
	logic [ACTIVITY_CNTR_W-1:0] activity_cntr;

	assign dev_index = req_i.addr.fields.dev_index;
	assign req_valid = (req_i.op != OP_NONE) && !sys_rst_i;
	assign inv_hit = (dev_index >= DEV_INDEX_W'(DEV_INVALID));

	// Each device sees the request, but only the addressed one gets a live op.
	always_comb begin
		for (int i = 0; i < DEV_COUNT - 1; i++) begin
			dev_req_o[i] = req_i;
			if (!req_valid || (dev_index != DEV_INDEX_W'(i))) begin
				dev_req_o[i].op = OP_NONE;
			end
		end
	end

	// Remember the target so its response can be picked next cycle.
	always_ff @(posedge clk100mhz_i) begin
		dev_sel_q <= inv_hit ? DEV_SEL_W'(DEV_INVALID) : dev_index[DEV_SEL_W-1:0];
	end

	// Built-in responder for anything outside the device windows.
	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			inv_rdy_q <= 1'b0;
		end else begin
			inv_rdy_q <= req_valid && inv_hit;
		end
	end

	// Invalid responder returns zero data.
	always_comb begin
		rsp_o = '0;
		rsp_o.rdy = inv_rdy_q;
		for (int i = 0; i < DEV_COUNT - 1; i++) begin
			if (dev_sel_q == DEV_SEL_W'(i)) begin
				rsp_o = dev_rsp_i[i];
			end
		end
	end

	// Dimmed indicator: one pulse, then blind for the counter period.
	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			activity_o <= 1'b0;
			activity_cntr <= '0;
		end else if (activity_cntr != '0) begin
			activity_o <= 1'b0;
			activity_cntr <= activity_cntr - 1'b1;
		end else if (req_valid && inv_hit) begin
			activity_o <= 1'b1;
			activity_cntr <= '1;
		end else begin
			activity_o <= 1'b0;
		end
	end

endmodule

// ==== design/soc_reset_ctrl.sv ====
// Reset sequencer combining the board reset, software resets and the power-off latch.
module soc_reset_ctrl (
	input  logic               clk100mhz_i,
	input  logic               rst_p,
	input  soc_pkg::rst_req_t  rst_req_i,
	output logic               sys_rst_o
);
	import soc_pkg::*;

	logic [RST_CNTR_W-1:0] rst_cntr;
	logic                  pwroff_q;

	// Reload on board reset or warm request, then count down to zero.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p || rst_req_i.warm) begin
			rst_cntr <= '1;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// Power-off holds the system in reset until the board reset button.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (rst_req_i.pwroff) begin
			pwroff_q <= 1'b1;
		end
	end

	// A cold request has already been folded into warm by the device table.
	assign sys_rst_o = (rst_cntr != '0) || pwroff_q;

endmodule

// ==== design/soc_pkg.sv ====
// SoC package holding bus sizes, device map, op codes, device table contents and bus types.
package soc_pkg;

	// Bus word and address sizes.
	localparam int ARCH_W = 32;
	localparam int SEL_W = ARCH_W / 8;
	localparam int ADDR_W = 30;
	localparam int DEV_OFFSET_W = 10;
	localparam int DEV_INDEX_W = ADDR_W - DEV_OFFSET_W;

	// Device indices, one 4 KB window each.
	localparam int DEV_DEVTBL = 0;
	localparam int DEV_GP0IO = 1;
	localparam int DEV_GP1IO = 2;
	localparam int DEV_INVALID = 3;
	localparam int DEV_COUNT = 4;
	localparam int DEV_SEL_W = $clog2(DEV_COUNT);

	// Port widths and counter sizes.
	localparam int GP0IO_COUNT = 16;
	localparam int GP1IO_COUNT = 5;
	localparam int RST_CNTR_W = 6;
	localparam int ACTIVITY_CNTR_W = 7;

	// Op codes, code 3 behaves as a read.
	localparam logic [1:0] OP_NONE = 2'd0;
	localparam logic [1:0] OP_WRITE = 2'd1;
	localparam logic [1:0] OP_READ = 2'd2;

	// Device table contents.
	localparam int DEVTBL_CTRL_OFFSET = 1023;
	localparam logic [DEV_COUNT-1:0][15:0] DEV_ID_TABLE = {16'd0, 16'd6, 16'd6, 16'd7};
	localparam logic [DEV_COUNT-1:0] DEV_USEINTR_TABLE = 4'b0110;
	localparam int DEV_MAPSZ = 2 ** DEV_OFFSET_W;

	typedef struct packed {
		logic [DEV_INDEX_W-1:0]  dev_index;
		logic [DEV_OFFSET_W-1:0] offset;
	} pi1_addr_fields_t;

	// Word address, seen flat or split into device index and offset.
	typedef union packed {
		logic [ADDR_W-1:0] word;
		pi1_addr_fields_t  fields;
	} pi1_addr_u;

	typedef struct packed {
		logic [1:0]        op;
		pi1_addr_u         addr;
		logic [ARCH_W-1:0] data;
		logic [SEL_W-1:0]  sel;
	} pi1_req_t;

	typedef struct packed {
		logic              rdy;
		logic [ARCH_W-1:0] data;
	} pi1_rsp_t;

	typedef struct packed {
		logic [15:0] id;
		logic        useintr;
		logic [14:0] mapsz;
	} devtbl_entry_t;

	typedef struct packed {
		logic warm;
		logic pwroff;
	} rst_req_t;

endpackage
